// File: compile.f
verilog/umi_pkg.sv
verilog/umi_if.sv
verilog/umi_merge_check.sv
verilog/umi_merge_accum.sv
verilog/umi_packet_merge_greedy.sv
verification/umi_merge_assertions.sv
verification/testbench.sv

// File: verification/testbench.sv
module testbench import umi_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int directed_count = 5;
    localparam int random_count = 400;
    localparam int cycle_limit = 4 * (directed_count + random_count) + 200;
    localparam logic [31:0] lfsr_seed = 32'h4957_0d8d;
    localparam logic [31:0] lfsr_taps = 32'h8020_0003;

    // Error categories
    localparam int t_cons = 0;
    localparam int t_merge = 1;
    localparam int t_pass = 2;
    localparam int t_greedy = 3;
    localparam int t_flow = 4;

    typedef struct packed {
        logic [cw-1:0]  cmd;
        logic [aw-1:0]  dstaddr;
        logic [aw-1:0]  srcaddr;
        logic [idw-1:0] data;
    } pkt_t;

    logic           clk;
    logic           nreset;
    logic           umi_in_valid;
    logic [cw-1:0]  umi_in_cmd;
    logic [aw-1:0]  umi_in_dstaddr;
    logic [aw-1:0]  umi_in_srcaddr;
    logic [idw-1:0] umi_in_data;
    logic           umi_in_ready;
    logic           umi_out_valid;
    logic [cw-1:0]  umi_out_cmd;
    logic [aw-1:0]  umi_out_dstaddr;
    logic [aw-1:0]  umi_out_srcaddr;
    logic [odw-1:0] umi_out_data;
    logic           umi_out_ready;

    logic [31:0]    lfsr;
    logic [aw-1:0]  next_dst;
    logic [aw-1:0]  next_src;
    logic           in_directed;
    int             cycles = 0;
    int             errors [5] = '{0, 0, 0, 0, 0};
    pkt_t           model_q [$];
    int             out_sizes [$];

    umi_packet_merge_greedy UUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ lfsr_taps) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic draw(input int n, output logic [idw-1:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            bits[i] = lfsr[0];
        end
    endtask

    function automatic logic [cw-1:0] make_cmd(input logic [opw-1:0] op, input logic eom);
        logic [cw-1:0] cmd;
        cmd = '0;
        cmd[opcode_msb:opcode_lsb] = op;
        cmd[len_msb:len_lsb] = 8'd15;      // 16 bytes at size 0
        cmd[eom_bit] = eom;
        return cmd;
    endfunction

    task automatic report_mismatch(input int cat, input string name,
                                   input logic [odw-1:0] expected,
                                   input logic [odw-1:0] actual);
        errors[cat]++;
        $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
    endtask

    task automatic report_problem(input int cat, input string msg);
        errors[cat]++;
        $display("ERROR: %s", msg);
    endtask

    function automatic int error_total();
        return errors[0] + errors[1] + errors[2] + errors[3] + errors[4] +
               UUT.merge_checks.assert_errors;
    endfunction

    task automatic print_counts();
        $display("Errors: cons %0d, merge %0d, pass %0d, greedy %0d, flow %0d, assert %0d",
                 errors[t_cons], errors[t_merge], errors[t_pass], errors[t_greedy],
                 errors[t_flow], UUT.merge_checks.assert_errors);
    endtask

    task automatic drive_packet(input logic [cw-1:0] cmd, input logic [aw-1:0] dst,
                                input logic [aw-1:0] src, input logic [idw-1:0] data);
        umi_in_valid <= 1'b1;
        umi_in_cmd <= cmd;
        umi_in_dstaddr <= dst;
        umi_in_srcaddr <= src;
        umi_in_data <= data;
    endtask

    task automatic random_packet();
        logic [idw-1:0] r;
        logic [opw-1:0] op;
        logic           eom;
        draw(3, r);
        case (r[2:0])
            3'd5: op = opcode_req_posted;
            3'd6: op = opcode_req_read;
            3'd7: op = opcode_resp_read;
            default: op = opcode_req_write;
        endcase
        draw(2, r);
        if (r[1:0] == 2'b00) begin    // Break the address run
            draw(1, r);
            if (r[0]) begin
                draw(12, r);
                next_dst = aw'(r[11:0]) << 4;
            end
            draw(1, r);
            next_src = r[0] ? 64'h2000 : 64'h1000;
        end
        draw(3, r);
        eom = (r[2:0] == 3'b111);
        draw(idw, r);
        drive_packet(make_cmd(op, eom), next_dst, next_src, r);
        next_dst = next_dst + in_bytes;
    endtask

    // Offer one packet and return on the edge that takes it
    task automatic send_and_wait(input logic eom, input logic [aw-1:0] dst);
        logic [idw-1:0] r;
        draw(idw, r);
        drive_packet(make_cmd(opcode_req_write, eom), dst, 64'h1000, r);
        do @(posedge clk); while (!umi_in_ready);
    endtask

    task automatic random_run(input int count);
        logic [idw-1:0] r;
        int             offered;
        logic           done;
        offered = 0;
        done = 1'b0;
        next_dst = 64'h8000;
        next_src = 64'h1000;
        while (!done) begin
            @(posedge clk);
            draw(2, r);
            umi_out_ready <= (r[1:0] != 2'b00);
            if (!umi_in_valid || umi_in_ready) begin
                if (offered == count) begin
                    umi_in_valid <= 1'b0;
                    done = 1'b1;
                end else begin
                    draw(2, r);
                    if (r[1:0] != 2'b00) begin
                        random_packet();
                        offered++;
                    end else begin
                        umi_in_valid <= 1'b0;
                    end
                end
            end
        end
    endtask

    task automatic wait_drain();
        do @(negedge clk); while (model_q.size() != 0);
    endtask

    // Pops the inputs that make up one output and compares
    task automatic check_output();
        pkt_t           p;
        pkt_t           first;
        pkt_t           last;
        logic [odw-1:0] exp_data;
        logic [cw-1:0]  exp_cmd;
        int             want;
        int             total;
        int             count;
        want = int'(cmd_bytes(umi_out_cmd));
        total = 0;
        count = 0;
        exp_data = '0;
        while (total < want && model_q.size() > 0) begin
            p = model_q.pop_front();
            if (count == 0) begin
                first = p;
            end else begin
                if (p.cmd[opcode_msb:opcode_lsb] != first.cmd[opcode_msb:opcode_lsb])
                    report_mismatch(t_merge, "merge opcode", first.cmd[opcode_msb:opcode_lsb],
                                    p.cmd[opcode_msb:opcode_lsb]);
                if (p.srcaddr != first.srcaddr)
                    report_mismatch(t_merge, "merge srcaddr", first.srcaddr, p.srcaddr);
                if (p.dstaddr != last.dstaddr + cmd_bytes(last.cmd))
                    report_mismatch(t_merge, "merge dstaddr", last.dstaddr + cmd_bytes(last.cmd),
                                    p.dstaddr);
                if (last.cmd[eom_bit])
                    report_problem(t_merge, "packet with eom was followed within one output");
            end
            if (total <= out_bytes - in_bytes) exp_data[total*8 +: idw] = p.data;
            total += int'(cmd_bytes(p.cmd));
            last = p;
            count++;
        end
        if (count == 0) begin
            report_problem(t_flow, "output transfer with no accepted input left in the model");
        end else begin
            if (total != want) report_mismatch(t_cons, "output length", total, want);
            exp_cmd = first.cmd;
            exp_cmd[len_msb:len_lsb] = lenw'((total >> first.cmd[size_msb:size_lsb]) - 1);
            exp_cmd[eom_bit] = last.cmd[eom_bit];
            if (umi_out_cmd != exp_cmd) report_mismatch(t_merge, "output cmd", exp_cmd, umi_out_cmd);
            if (umi_out_dstaddr != first.dstaddr)
                report_mismatch(t_cons, "output dstaddr", first.dstaddr, umi_out_dstaddr);
            if (umi_out_srcaddr != first.srcaddr)
                report_mismatch(t_cons, "output srcaddr", first.srcaddr, umi_out_srcaddr);
            if (umi_out_data != exp_data)
                report_mismatch(t_cons, "output data", exp_data, umi_out_data);
            if (!cmd_mergeable_op(first.cmd[opcode_msb:opcode_lsb])) begin
                if (count != 1) report_mismatch(t_pass, "pass-through packet count", 1, count);
                if (umi_out_data[odw-1:idw] != '0)
                    report_mismatch(t_pass, "pass-through upper data", '0,
                                    umi_out_data[odw-1:idw]);
            end
        end
    endtask

    // Monitor and model
    always @(posedge clk) begin
        if (nreset) begin
            if (umi_out_valid && !umi_out_ready && umi_in_ready)
                report_problem(t_flow, "input ready while the output register is stalled");
            if (umi_out_valid && umi_out_ready) begin
                if (in_directed) out_sizes.push_back(int'(cmd_bytes(umi_out_cmd)));
                check_output();
            end
            if (umi_in_valid && umi_in_ready)
                model_q.push_back({umi_in_cmd, umi_in_dstaddr, umi_in_srcaddr, umi_in_data});
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            if (model_q.size() != 0)
                $display("Model queue still holds %0d accepted packets", model_q.size());
            print_counts();
            $display("test failed");
            $finish;
        end
    end

    initial begin
        nreset = 1'b0;
        umi_in_valid = 1'b0;
        umi_in_cmd = '0;
        umi_in_dstaddr = '0;
        umi_in_srcaddr = '0;
        umi_in_data = '0;
        umi_out_ready = 1'b1;
        lfsr = lfsr_seed;
        in_directed = 1'b1;
        repeat (10) @(posedge clk);
        nreset <= 1'b1;
        @(negedge clk);
        if (umi_out_valid != 1'b0)
            report_mismatch(t_flow, "out valid after reset", 0, umi_out_valid);
        if (umi_in_ready != 1'b1) report_mismatch(t_flow, "in ready after reset", 1, umi_in_ready);

        // Four contiguous writes close with eom, the fifth opens a new output
        @(posedge clk);
        send_and_wait(1'b0, 64'h4000);
        send_and_wait(1'b0, 64'h4010);
        send_and_wait(1'b0, 64'h4020);
        send_and_wait(1'b1, 64'h4030);
        send_and_wait(1'b0, 64'h4040);
        umi_in_valid <= 1'b0;
        wait_drain();
        in_directed = 1'b0;
        if (out_sizes.size() != 2) begin
            report_mismatch(t_greedy, "greedy output count", 2, out_sizes.size());
        end else begin
            if (out_sizes[0] != 64)
                report_mismatch(t_greedy, "greedy first bytes", 64, out_sizes[0]);
            if (out_sizes[1] != 16)
                report_mismatch(t_greedy, "greedy second bytes", 16, out_sizes[1]);
        end

        random_run(random_count);
        umi_out_ready <= 1'b1;
        wait_drain();
        repeat (4) @(negedge clk);     // Nothing extra may come out

        print_counts();
        if (error_total() == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: verification/umi_merge_assertions.sv
module umi_merge_assertions import umi_pkg::*; (
    input logic           clk,
    input logic           nreset,
    input logic           umi_out_valid,
    input logic           umi_out_ready,
    input logic [cw-1:0]  umi_out_cmd,
    input logic [aw-1:0]  umi_out_dstaddr,
    input logic [aw-1:0]  umi_out_srcaddr,
    input logic [odw-1:0] umi_out_data
);
    timeunit 1ns;
    timeprecision 1ps;

    int assert_errors = 0;

    // Stalled output holds its whole payload
    property stalled_payload_stable;
        @(posedge clk) disable iff (!nreset)
        umi_out_valid && !umi_out_ready |=>
            umi_out_valid && $stable(umi_out_cmd) && $stable(umi_out_dstaddr) &&
            $stable(umi_out_srcaddr) && $stable(umi_out_data);
    endproperty

    property out_len_in_range;
        @(posedge clk) disable iff (!nreset)
        umi_out_valid |-> cmd_bytes(umi_out_cmd) <= out_bytes;
    endproperty

    stable_chk: assert property (stalled_payload_stable) else begin
        assert_errors++;
        $error("output payload changed while stalled");
    end

    len_chk: assert property (out_len_in_range) else begin
        assert_errors++;
        $error("output length beyond the wide data width");
    end

    reset_chk: assert property (@(posedge clk) $rose(nreset) |-> !umi_out_valid) else begin
        assert_errors++;
        $error("output valid high right after reset");
    end

endmodule

bind umi_packet_merge_greedy umi_merge_assertions merge_checks (
    .clk             (clk),
    .nreset          (nreset),
    .umi_out_valid   (umi_out_valid),
    .umi_out_ready   (umi_out_ready),
    .umi_out_cmd     (umi_out_cmd),
    .umi_out_dstaddr (umi_out_dstaddr),
    .umi_out_srcaddr (umi_out_srcaddr),
    .umi_out_data    (umi_out_data)
);

// File: verilog/umi_if.sv
interface umi_if import umi_pkg::*; #(
    parameter int dw = idw
);

    logic          valid;
    logic [cw-1:0] cmd;
    logic [aw-1:0] dstaddr;
    logic [aw-1:0] srcaddr;
    logic [dw-1:0] data;
    logic          ready;

    modport src (
        output valid,
        output cmd,
        output dstaddr,
        output srcaddr,
        output data,
        input  ready
    );

    modport dst (
        input  valid,
        input  cmd,
        input  dstaddr,
        input  srcaddr,
        input  data,
        output ready
    );

endinterface

// File: verilog/umi_merge_accum.sv
module umi_merge_accum import umi_pkg::*; (
    input  logic           clk,
    input  logic           nreset,

    umi_if.dst             in_ch,
    umi_if.src             out_ch,

    input  logic           join_en,
    input  logic           flush,

    output logic           held_valid,
    output logic [cw-1:0]  held_cmd,
    output logic [aw-1:0]  held_end_addr,
    output logic [aw-1:0]  held_srcaddr,
    output logic [bcw-1:0] held_bytes
);

    logic           accept;
    logic [bcw-1:0] in_cnt;
    logic [bcw-1:0] new_bytes;
    logic [idw-1:0] in_masked;
    logic [odw-1:0] in_placed;

    logic [aw-1:0]  held_dstaddr;
    logic [odw-1:0] held_data;

    logic           out_valid;
    logic [cw-1:0]  out_cmd;
    logic [aw-1:0]  out_dstaddr;
    logic [aw-1:0]  out_srcaddr;
    logic [odw-1:0] out_data;

    // Stall input while the output register is full and not draining
    assign in_ch.ready = !out_valid || out_ch.ready;
    assign accept = in_ch.valid && in_ch.ready;

    assign in_cnt = cmd_bytes(in_ch.cmd);
    assign new_bytes = held_bytes + in_cnt;

    // Drop bytes beyond the packet's own length
    always_comb begin
        for (int i = 0; i < in_bytes; i++) begin
            in_masked[i*8 +: 8] = (i < in_cnt) ? in_ch.data[i*8 +: 8] : 8'h00;
        end
    end

    assign in_placed = {{(odw-idw){1'b0}}, in_masked} << {held_bytes, 3'b000};

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            held_valid <= 1'b0;
        end else if (accept) begin
            held_valid <= 1'b1;      // Joined or a fresh packet
        end else if (flush) begin
            held_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && join_en) begin
            held_data <= held_data | in_placed;
            held_bytes <= new_bytes;
            held_cmd[len_msb:len_lsb] <= cmd_len_for(new_bytes, cmd_size(held_cmd));
            held_cmd[eom_bit] <= cmd_eom(in_ch.cmd);
        end else if (accept) begin
            // Reserved bits come from the first packet
            held_cmd <= in_ch.cmd;
            held_dstaddr <= in_ch.dstaddr;
            held_srcaddr <= in_ch.srcaddr;
            held_bytes <= in_cnt;
            held_data <= {{(odw-idw){1'b0}}, in_masked};
        end
    end

    assign held_end_addr = held_dstaddr + aw'(held_bytes);

    // Output register
    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b1;
        end else if (out_ch.ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (flush) begin
            out_cmd <= held_cmd;
            out_dstaddr <= held_dstaddr;
            out_srcaddr <= held_srcaddr;
            out_data <= held_data;
        end
    end

    assign out_ch.valid = out_valid;
    assign out_ch.cmd = out_cmd;
    assign out_ch.dstaddr = out_dstaddr;
    assign out_ch.srcaddr = out_srcaddr;
    assign out_ch.data = out_data;

endmodule

// File: verilog/umi_merge_check.sv
module umi_merge_check import umi_pkg::*; (
    input  logic           clk,
    input  logic           nreset,

    umi_if.dst             in_ch,

    input  logic           held_valid,
    input  logic [cw-1:0]  held_cmd,
    input  logic [aw-1:0]  held_end_addr,
    input  logic [aw-1:0]  held_srcaddr,
    input  logic [bcw-1:0] held_bytes,

    output logic           join_en,
    output logic           flush
);

    logic           valid_q;
    logic [opw-1:0] in_opcode;
    logic [bcw-1:0] in_cnt;
    logic [bcw:0]   total;
    logic           same_hdr;
    logic           contiguous;
    logic           fits;
    logic           held_eom;
    logic           held_full;
    logic           match;
    logic           idle;
    logic           no_join;

    // Last input valid, kept while a stalled packet waits
    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            valid_q <= 1'b0;
        end else if (!in_ch.valid || in_ch.ready) begin
            valid_q <= in_ch.valid;
        end
    end

    assign in_opcode = cmd_opcode(in_ch.cmd);
    assign in_cnt = cmd_bytes(in_ch.cmd);
    assign total = {1'b0, held_bytes} + {1'b0, in_cnt};

    // Header compare against the held packet
    assign same_hdr = cmd_mergeable_op(in_opcode) &&
                      (in_opcode == cmd_opcode(held_cmd)) &&
                      (cmd_size(in_ch.cmd) == cmd_size(held_cmd)) &&
                      (in_ch.srcaddr == held_srcaddr);

    assign contiguous = (in_ch.dstaddr == held_end_addr);
    assign fits = (total <= (bcw+1)'(out_bytes));

    assign held_eom = cmd_eom(held_cmd);
    assign held_full = (held_bytes >= bcw'(out_bytes));

    assign match = same_hdr && contiguous && fits && !held_eom;

    // A gap seen while the output was stalled still ends the merge
    assign idle = !in_ch.valid || !valid_q;
    assign no_join = in_ch.valid && !match;

    // Only acts when the output register can take a packet
    assign join_en = held_valid && in_ch.ready && !idle && match;
    assign flush = held_valid && in_ch.ready &&
                   (idle || no_join || held_eom || held_full);

endmodule

// File: verilog/umi_packet_merge_greedy.sv
module umi_packet_merge_greedy import umi_pkg::*; (
    input  logic           clk,
    input  logic           nreset,

    input  logic           umi_in_valid,
    input  logic [cw-1:0]  umi_in_cmd,
    input  logic [aw-1:0]  umi_in_dstaddr,
    input  logic [aw-1:0]  umi_in_srcaddr,
    input  logic [idw-1:0] umi_in_data,
    output logic           umi_in_ready,

    output logic           umi_out_valid,
    output logic [cw-1:0]  umi_out_cmd,
    output logic [aw-1:0]  umi_out_dstaddr,
    output logic [aw-1:0]  umi_out_srcaddr,
    output logic [odw-1:0] umi_out_data,
    input  logic           umi_out_ready
);

    logic           join_en;
    logic           flush;

    logic           held_valid;
    logic [cw-1:0]  held_cmd;
    logic [aw-1:0]  held_end_addr;
    logic [aw-1:0]  held_srcaddr;
    logic [bcw-1:0] held_bytes;

    umi_if #(.dw(idw)) in_ch ();
    umi_if #(.dw(odw)) out_ch ();

    // Narrow side
    assign in_ch.valid = umi_in_valid;
    assign in_ch.cmd = umi_in_cmd;
    assign in_ch.dstaddr = umi_in_dstaddr;
    assign in_ch.srcaddr = umi_in_srcaddr;
    assign in_ch.data = umi_in_data;
    assign umi_in_ready = in_ch.ready;

    // Wide side
    assign umi_out_valid = out_ch.valid;
    assign umi_out_cmd = out_ch.cmd;
    assign umi_out_dstaddr = out_ch.dstaddr;
    assign umi_out_srcaddr = out_ch.srcaddr;
    assign umi_out_data = out_ch.data;
    assign out_ch.ready = umi_out_ready;

    umi_merge_check check_i (
        .clk           (clk),
        .nreset        (nreset),
        .in_ch         (in_ch),
        .held_valid    (held_valid),
        .held_cmd      (held_cmd),
        .held_end_addr (held_end_addr),
        .held_srcaddr  (held_srcaddr),
        .held_bytes    (held_bytes),
        .join_en       (join_en),
        .flush         (flush)
    );

    umi_merge_accum accum_i (
        .clk           (clk),
        .nreset        (nreset),
        .in_ch         (in_ch),
        .out_ch        (out_ch),
        .join_en       (join_en),
        .flush         (flush),
        .held_valid    (held_valid),
        .held_cmd      (held_cmd),
        .held_end_addr (held_end_addr),
        .held_srcaddr  (held_srcaddr),
        .held_bytes    (held_bytes)
    );

endmodule

// File: verilog/umi_pkg.sv
package umi_pkg;

    localparam int cw = 32;
    localparam int aw = 64;
    localparam int idw = 128;
    localparam int odw = 512;

    localparam int in_bytes = idw / 8;
    localparam int out_bytes = odw / 8;

    // Wide enough for (255 + 1) << 7
    localparam int bcw = 16;

    // Command field positions
    localparam int opcode_lsb = 0;
    localparam int opcode_msb = 4;
    localparam int size_lsb = 5;
    localparam int size_msb = 7;
    localparam int len_lsb = 8;
    localparam int len_msb = 15;
    localparam int eom_bit = 22;

    localparam int opw = opcode_msb - opcode_lsb + 1;
    localparam int szw = size_msb - size_lsb + 1;
    localparam int lenw = len_msb - len_lsb + 1;

    localparam logic [opw-1:0] opcode_req_read = 5'h01;
    localparam logic [opw-1:0] opcode_resp_read = 5'h02;
    localparam logic [opw-1:0] opcode_req_write = 5'h03;
    localparam logic [opw-1:0] opcode_req_posted = 5'h05;

    function automatic logic [opw-1:0] cmd_opcode(input logic [cw-1:0] cmd);
        return cmd[opcode_msb:opcode_lsb];
    endfunction

    function automatic logic [szw-1:0] cmd_size(input logic [cw-1:0] cmd);
        return cmd[size_msb:size_lsb];
    endfunction

    function automatic logic [lenw-1:0] cmd_len(input logic [cw-1:0] cmd);
        return cmd[len_msb:len_lsb];
    endfunction

    function automatic logic cmd_eom(input logic [cw-1:0] cmd);
        return cmd[eom_bit];
    endfunction

    // Bytes moved by one command
    function automatic logic [bcw-1:0] cmd_bytes(input logic [cw-1:0] cmd);
        logic [bcw-1:0] units;
        units = bcw'(cmd_len(cmd)) + 1'b1;
        return units << cmd_size(cmd);
    endfunction

    // Inverse of cmd_bytes for a given size
    function automatic logic [lenw-1:0] cmd_len_for(input logic [bcw-1:0] bytes,
                                                    input logic [szw-1:0] size);
        logic [bcw-1:0] units;
        units = bytes >> size;
        return lenw'(units - 1'b1);
    endfunction

    function automatic logic cmd_mergeable_op(input logic [opw-1:0] opcode);
        return (opcode == opcode_req_write) || (opcode == opcode_req_posted);
    endfunction

endpackage
